// File: tb.f
+incdir+src
src/apb_chk_pkg.sv
src/apb_transfer_monitor.sv
src/viol_log_fifo.sv
src/viol_tally.sv
src/apb_protocol_checker.sv
test/tb_apb_protocol_checker.sv

// File: test/tb_apb_protocol_checker.sv
// Self-checking testbench for the default macro sizes; stops at the first wrong value
`timescale 1ns/1ns
`include "apb_chk_macros.svh"

module tb_apb_protocol_checker;

  localparam int TIMEOUT_CYCLES = 4000;
  // Fault flag positions for drive_transfer
  localparam int F_EN_SETUP  = 0;
  localparam int F_EN_LOW    = 1;
  localparam int F_PSEL_DROP = 2;
  localparam int F_CHG_ADDR  = 3;
  localparam int F_CHG_WRITE = 4;
  localparam int F_CHG_DATA  = 5;

  // One bus sample as the reference model sees it
  typedef struct packed {
    logic                psel;
    logic                penable;
    logic                pwrite;
    logic                pready;
    apb_chk_pkg::paddr_t paddr;
    apb_chk_pkg::pdata_t pwdata;
  } bus_smp_t;

  logic                    PCLK = 1'b0;
  logic                    PRESETn;
  logic                    PSEL;
  logic                    PENABLE;
  logic                    PWRITE;
  logic                    PREADY;
  apb_chk_pkg::paddr_t     PADDR;
  apb_chk_pkg::pdata_t     PWDATA;
  apb_chk_pkg::err_count_t error_count;
  apb_chk_pkg::rule_vec_t  rule_seen;
  logic                    log_overflow;
  logic                    busy;

  // Model state that mirrors the monitor
  bus_smp_t                prev_smp;
  apb_chk_pkg::bus_phase_e model_phase;
  int                      wd_left;
  // Expected totals and the values at the last checkpoint
  int                      exp_count;
  apb_chk_pkg::rule_vec_t  exp_seen;
  int                      base_count;
  apb_chk_pkg::rule_vec_t  base_seen;
  // Sum of the per-test counts that the fault list predicts
  int                      plan_total;
  apb_chk_pkg::rule_vec_t  plan_bits;
  int                      fail_count = 0;
  int                      cycle_cnt = 0;
  integer                  seed;

  apb_protocol_checker u_apb_protocol_checker (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .PSEL         (PSEL),
    .PENABLE      (PENABLE),
    .PWRITE       (PWRITE),
    .PREADY       (PREADY),
    .PADDR        (PADDR),
    .PWDATA       (PWDATA),
    .error_count  (error_count),
    .rule_seen    (rule_seen),
    .log_overflow (log_overflow),
    .busy         (busy)
  );

  // 100 ns period
  always #50 PCLK = ~PCLK;

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////

  // Rules for one sample from the last sample, phase and watchdog count
  function automatic apb_chk_pkg::rule_vec_t expected_rules(bus_smp_t cur, bus_smp_t prev,
                                                           apb_chk_pkg::bus_phase_e phase,
                                                           int wd);
    apb_chk_pkg::rule_vec_t r;
    logic                   setup;
    logic                   held;
    logic                   reload;
    r      = '0;
    setup  = cur.psel && (!prev.psel || (prev.penable && prev.pready));
    // Transfer still open from the last sample
    held   = cur.psel && prev.psel && !prev.pready;
    reload = !cur.psel || (cur.penable && cur.pready);
    r[apb_chk_pkg::RULE_PSEL_DROP]       = !cur.psel && prev.psel && !prev.pready;
    r[apb_chk_pkg::RULE_PENABLE_SETUP]   = setup && cur.penable;
    r[apb_chk_pkg::RULE_PENABLE_ACCESS]  = (phase == apb_chk_pkg::PH_ACCESS) && !cur.penable;
    r[apb_chk_pkg::RULE_PADDR_UNSTABLE]  = held && (cur.paddr != prev.paddr);
    r[apb_chk_pkg::RULE_PWRITE_UNSTABLE] = held && (cur.pwrite != prev.pwrite);
    r[apb_chk_pkg::RULE_PWDATA_UNSTABLE] = held && (cur.pwdata != prev.pwdata);
    r[apb_chk_pkg::RULE_PADDR_ALIGN]     = cur.psel && (cur.paddr[1:0] != 2'b00);
    // Only the step that reaches zero
    r[apb_chk_pkg::RULE_WATCHDOG]        = !reload && (wd == 1);
    return r;
  endfunction

  function automatic int bit_total(apb_chk_pkg::rule_vec_t v);
    int n;
    n = 0;
    for (int i = 0; i < 8; i++)
      n = n + v[i];
    return n;
  endfunction

  function automatic apb_chk_pkg::rule_vec_t one_rule(apb_chk_pkg::rule_idx_e idx);
    apb_chk_pkg::rule_vec_t v;
    v      = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  // Samples the bus on each rising edge with inputs settled 5 ns after the last one
  always @(posedge PCLK or negedge PRESETn)
  begin : ref_model
    bus_smp_t               cur;
    apb_chk_pkg::rule_vec_t rules;
    logic                   setup;
    if (!PRESETn)
    begin
      prev_smp        = '0;
      prev_smp.pready = 1'b1;
      model_phase     = apb_chk_pkg::PH_IDLE;
      wd_left         = `APB_CHK_WATCHDOG_CYCLES;
      exp_count       = 0;
      exp_seen        = '0;
    end
    else
    begin
      cur       = {PSEL, PENABLE, PWRITE, PREADY, PADDR, PWDATA};
      rules     = expected_rules(cur, prev_smp, model_phase, wd_left);
      exp_count = exp_count + bit_total(rules);
      exp_seen  = exp_seen | rules;
      setup     = cur.psel && (!prev_smp.psel || (prev_smp.penable && prev_smp.pready));
      // Setup sample moves straight on to access
      if (setup)
        model_phase = apb_chk_pkg::PH_ACCESS;
      else if ((model_phase == apb_chk_pkg::PH_ACCESS) && (cur.pready || !cur.psel))
        model_phase = apb_chk_pkg::PH_IDLE;
      if (!cur.psel || (cur.penable && cur.pready))
        wd_left = `APB_CHK_WATCHDOG_CYCLES;
      else if (wd_left > 0)
        wd_left = wd_left - 1;
      prev_smp = cur;
    end
  end

  //////////////////////////////////////////////////
  // Checks and timeout
  //////////////////////////////////////////////////

  task automatic check_value(input string what, input int got, input int exp);
    assert (got == exp)
    else
    begin
      $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      fail_count++;
      $display("TESTS FAILED");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  always @(posedge PCLK)
  begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES)
    begin
      $display("The run stalled and did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "Timeout");
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic drive_idle(input int cycles);
    repeat (cycles)
    begin
      @(posedge PCLK);
      #5;
      PSEL    = 1'b0;
      PENABLE = 1'b0;
      PREADY  = 1'b0;
    end
  endtask

  // Setup sample, then waits access samples with PREADY low and one completing
  task automatic drive_transfer(input apb_chk_pkg::paddr_t addr, input logic wr,
                                input apb_chk_pkg::pdata_t data, input int waits,
                                input logic [5:0] faults);
    int   i;
    logic dropped;
    dropped = 1'b0;
    @(posedge PCLK);
    #5;
    PSEL    = 1'b1;
    PENABLE = faults[F_EN_SETUP];
    PADDR   = addr;
    PWRITE  = wr;
    PWDATA  = data;
    PREADY  = 1'b0;
    for (i = 0; (i <= waits) && !dropped; i++)
    begin
      @(posedge PCLK);
      #5;
      PENABLE = !(faults[F_EN_LOW] && (i == 0));
      PREADY  = (i == waits);
      // Mid-transfer faults land on the second access sample
      if (i == 1)
      begin
        if (faults[F_CHG_ADDR])
          PADDR = addr + 32'd4;
        if (faults[F_CHG_WRITE])
          PWRITE = !wr;
        if (faults[F_CHG_DATA])
          PWDATA = data ^ 32'h1;
        if (faults[F_PSEL_DROP])
        begin
          // PENABLE kept high so only the drop rule applies
          PSEL    = 1'b0;
          dropped = 1'b1;
        end
      end
    end
  endtask

  // Let the log drain, then compare totals and the per-test increase
  task automatic settle_and_check(input string name, input int added,
                                  input apb_chk_pkg::rule_vec_t bits);
    drive_idle(10);
    while (busy)
      drive_idle(1);
    plan_total = plan_total + added;
    plan_bits  = plan_bits | bits;
    check_value({name, ": error_count"}, error_count, exp_count);
    check_value({name, ": rule_seen"}, rule_seen, exp_seen);
    check_value({name, ": count added"}, int'(error_count) - base_count, added);
    check_value({name, ": new rule bits"}, rule_seen & ~base_seen, bits & ~base_seen);
    check_value({name, ": log_overflow"}, log_overflow, 0);
    base_count = exp_count;
    base_seen  = exp_seen;
  endtask

  task automatic check_reset_values();
    check_value("reset error_count", error_count, 0);
    check_value("reset rule_seen", rule_seen, 0);
    check_value("reset log_overflow", log_overflow, 0);
    check_value("reset busy", busy, 0);
  endtask

  initial
  begin : stimulus
    apb_chk_pkg::paddr_t addr;
    apb_chk_pkg::pdata_t data;
    seed       = 32'h8d40584f;
    PRESETn    = 1'b0;
    PSEL       = 1'b0;
    PENABLE    = 1'b0;
    PWRITE     = 1'b0;
    PREADY     = 1'b0;
    PADDR      = '0;
    PWDATA     = '0;
    base_count = 0;
    base_seen  = '0;
    plan_total = 0;
    plan_bits  = '0;
    repeat (5) @(posedge PCLK);
    #5;
    check_reset_values();
    PRESETn = 1'b1;

    // Legal traffic with some of it back to back
    repeat (40)
    begin
      addr      = $random(seed);
      addr[1:0] = 2'b00;
      data      = $random(seed);
      drive_transfer(addr, data[7], data, $unsigned($random(seed)) % 4, 6'b0);
      drive_idle($unsigned($random(seed)) % 2);
    end
    settle_and_check("clean traffic", 0, '0);

    // Single faults
    drive_transfer(32'h0000_1002, 1'b1, $random(seed), 1, 6'b0);
    settle_and_check("misaligned", 3, one_rule(apb_chk_pkg::RULE_PADDR_ALIGN));
    drive_transfer(32'h0000_2000, 1'b0, $random(seed), 1, 6'b000001);
    settle_and_check("penable setup", 1, one_rule(apb_chk_pkg::RULE_PENABLE_SETUP));
    drive_transfer(32'h0000_3000, 1'b1, $random(seed), 2, 6'b000010);
    settle_and_check("penable access", 1, one_rule(apb_chk_pkg::RULE_PENABLE_ACCESS));
    drive_transfer(32'h0000_4000, 1'b1, $random(seed), 3, 6'b000100);
    settle_and_check("psel drop", 1, one_rule(apb_chk_pkg::RULE_PSEL_DROP));

    // Stability faults where the last one changes two fields at once
    drive_transfer(32'h0000_5000, 1'b1, $random(seed), 3, 6'b001000);
    settle_and_check("paddr change", 1, one_rule(apb_chk_pkg::RULE_PADDR_UNSTABLE));
    drive_transfer(32'h0000_6000, 1'b0, $random(seed), 3, 6'b010000);
    settle_and_check("pwrite change", 1, one_rule(apb_chk_pkg::RULE_PWRITE_UNSTABLE));
    drive_transfer(32'h0000_7000, 1'b1, $random(seed), 3, 6'b100000);
    settle_and_check("pwdata change", 1, one_rule(apb_chk_pkg::RULE_PWDATA_UNSTABLE));
    drive_transfer(32'h0000_8000, 1'b1, $random(seed), 3, 6'b101000);
    settle_and_check("paddr and pwdata change", 2,
                     one_rule(apb_chk_pkg::RULE_PADDR_UNSTABLE) |
                     one_rule(apb_chk_pkg::RULE_PWDATA_UNSTABLE));

    // Two stalled transfers with one watchdog hit each
    drive_transfer(32'h0000_9000, 1'b0, $random(seed), 20, 6'b0);
    settle_and_check("watchdog 1", 1, one_rule(apb_chk_pkg::RULE_WATCHDOG));
    drive_transfer(32'h0000_a000, 1'b1, $random(seed), 20, 6'b0);
    settle_and_check("watchdog 2", 1, one_rule(apb_chk_pkg::RULE_WATCHDOG));

    // Summary against the fault list and then a reset in the middle of the run
    check_value("summary error_count", error_count, plan_total);
    check_value("summary rule_seen", rule_seen, plan_bits);
    @(posedge PCLK);
    #5;
    PRESETn = 1'b0;
    @(posedge PCLK);
    #5;
    check_reset_values();
    PRESETn = 1'b1;

    if (fail_count == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

// File: src/apb_protocol_checker.sv
// Passive APB3 checker top; all bus inputs are sampled on rising PCLK and never driven
`timescale 1ns/1ns
`include "apb_chk_macros.svh"

module apb_protocol_checker
(
  input  logic                    PCLK,
  input  logic                    PRESETn,
  input  logic                    PSEL,
  input  logic                    PENABLE,
  input  logic                    PWRITE,
  input  logic                    PREADY,
  input  apb_chk_pkg::paddr_t     PADDR,
  input  apb_chk_pkg::pdata_t     PWDATA,
  output apb_chk_pkg::err_count_t error_count,
  output apb_chk_pkg::rule_vec_t  rule_seen,
  output logic                    log_overflow,
  output logic                    busy
);

  //////////////////////////////////////////////////
  // Inter-stage signals
  //////////////////////////////////////////////////

  // Monitor to log
  logic                   rec_push;
  apb_chk_pkg::viol_rec_t rec;

  // Log to tally
  logic                   log_pop;
  logic                   log_empty;
  apb_chk_pkg::viol_rec_t log_head;

  // Phase tracking and rule evaluation
  apb_transfer_monitor u_monitor (
    .PCLK     (PCLK),
    .PRESETn  (PRESETn),
    .psel     (PSEL),
    .penable  (PENABLE),
    .pwrite   (PWRITE),
    .pready   (PREADY),
    .paddr    (PADDR),
    .pwdata   (PWDATA),
    .rec_push (rec_push),
    .rec      (rec)
  );

  // Buffer between a bursty monitor and the bit-serial tally
  viol_log_fifo u_log (
    .PCLK         (PCLK),
    .PRESETn      (PRESETn),
    .rec_push     (rec_push),
    .rec          (rec),
    .log_pop      (log_pop),
    .log_head     (log_head),
    .log_empty    (log_empty),
    .log_full     (),
    .log_overflow (log_overflow)
  );

  viol_tally u_tally (
    .PCLK        (PCLK),
    .PRESETn     (PRESETn),
    .log_head    (log_head),
    .log_empty   (log_empty),
    .log_pop     (log_pop),
    .error_count (error_count),
    .rule_seen   (rule_seen),
    .busy        (busy)
  );

endmodule

// File: src/viol_tally.sv
// Drains the log one rule bit per cycle; error count saturates at its all-ones value
`timescale 1ns/1ns
`include "apb_chk_macros.svh"

module viol_tally
(
  input  logic                   PCLK,
  input  logic                   PRESETn,
  input  apb_chk_pkg::viol_rec_t log_head,
  input  logic                   log_empty,
  output logic                   log_pop,
  output apb_chk_pkg::err_count_t error_count,
  output apb_chk_pkg::rule_vec_t rule_seen,
  output logic                   busy
);

  localparam apb_chk_pkg::err_count_t COUNT_MAX = {`APB_CHK_COUNT_W{1'b1}};

  // Bits of the current record still to be counted
  apb_chk_pkg::rule_vec_t work_q;
  // Lowest pending bit, counted this cycle
  apb_chk_pkg::rule_vec_t low_bit;
  // Pending bits left once low_bit is gone
  apb_chk_pkg::rule_vec_t work_rest;
  logic                   last_bit;

  //////////////////////////////////////////////////
  // Bit extraction
  //////////////////////////////////////////////////

  // Two's complement trick isolates the lowest one
  assign low_bit   = work_q & (~work_q + 1'b1);
  assign work_rest = work_q & (work_q - 1'b1);
  // Zero or one bit pending
  assign last_bit  = (work_rest == '0);

  // Refill in the same cycle the last bit is counted
  // so single-bit records drain at one per cycle
  assign log_pop = !log_empty && last_bit;

  // Work still in the log or in the working vector
  assign busy = (work_q != '0) || !log_empty;

  //////////////////////////////////////////////////
  // Working vector and results
  //////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      work_q      <= '0;
      error_count <= '0;
      rule_seen   <= '0;
    end
    else
    begin
      if (log_pop)
        work_q <= log_head.rules;
      else
        work_q <= work_rest;

      // One violation per counted bit
      if ((work_q != '0) && (error_count != COUNT_MAX))
        error_count <= error_count + 1'b1;

      // Sticky summary of every rule ever hit
      rule_seen <= rule_seen | low_bit;
    end
  end

endmodule

// File: src/viol_log_fifo.sv
// Record log of LOG_DEPTH entries (2 or more); pushes while full are lost and flagged
`timescale 1ns/1ns
`include "apb_chk_macros.svh"

module viol_log_fifo
(
  input  logic                   PCLK,
  input  logic                   PRESETn,
  input  logic                   rec_push,
  input  apb_chk_pkg::viol_rec_t rec,
  input  logic                   log_pop,
  output apb_chk_pkg::viol_rec_t log_head,
  output logic                   log_empty,
  output logic                   log_full,
  output logic                   log_overflow
);

  localparam int DEPTH = `APB_CHK_LOG_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage array
  apb_chk_pkg::viol_rec_t mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  // Occupancy tells full from empty when the pointers meet
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign log_empty = (count == '0);
  assign log_full  = (count == CNT_W'(DEPTH));
  assign do_push   = rec_push && !log_full;
  assign do_pop    = log_pop && !log_empty;
  // Oldest record sits at the read pointer
  assign log_head  = mem[rd_ptr];

  always_ff @(posedge PCLK)
  begin
    if (do_push)
      mem[wr_ptr] <= rec;
  end

  //////////////////////////////////////////////////
  // Pointers, occupancy and overflow
  //////////////////////////////////////////////////

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      count        <= '0;
      log_overflow <= 1'b0;
    end
    else
    begin
      // Wrap explicitly so any depth works
      if (do_push)
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop)
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      // Sticky until reset
      if (rec_push && log_full)
        log_overflow <= 1'b1;
    end
  end

  // Tally must only pop what the log holds
  a_no_pop_when_empty : assert property (@(posedge PCLK) disable iff (!PRESETn)
    log_pop |-> !log_empty);

endmodule

// File: src/apb_transfer_monitor.sv
// Passive APB3 sampler; needs DATA_W of 16 or more and reports one record per bad sample
`timescale 1ns/1ns
`include "apb_chk_macros.svh"

module apb_transfer_monitor
(
  input  logic                   PCLK,
  input  logic                   PRESETn,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic                   pready,
  input  apb_chk_pkg::paddr_t    paddr,
  input  apb_chk_pkg::pdata_t    pwdata,
  output logic                   rec_push,
  output apb_chk_pkg::viol_rec_t rec
);

  // Low address bits that must be zero for a full-word access
  localparam int ALIGN_W = $clog2(`APB_CHK_DATA_W / 8);
  // Counter just wide enough for the watchdog load value
  localparam int WD_W = $clog2(`APB_CHK_WATCHDOG_CYCLES + 1);
  localparam logic [WD_W-1:0] WD_LOAD = WD_W'(`APB_CHK_WATCHDOG_CYCLES);

  // Previous bus sample
  logic                    prev_psel;
  logic                    prev_penable;
  logic                    prev_pready;
  logic                    prev_pwrite;
  apb_chk_pkg::paddr_t     prev_paddr;
  apb_chk_pkg::pdata_t     prev_pwdata;

  // Phase tracking
  apb_chk_pkg::bus_phase_e state_q;
  apb_chk_pkg::bus_phase_e state_d;
  apb_chk_pkg::bus_phase_e cur_phase;
  logic                    setup_cycle;
  logic                    access_cycle;
  logic                    mid_transfer;

  // Watchdog
  logic [WD_W-1:0]         wd_cnt;
  logic                    wd_reload;
  logic                    wd_expire;

  apb_chk_pkg::rule_vec_t  rules_d;

  //////////////////////////////////////////////////
  // Phase decode
  //////////////////////////////////////////////////

  // New transfer starts after idle or right after a completed access
  assign setup_cycle  = psel && (!prev_psel || (prev_penable && prev_pready));
  assign access_cycle = (state_q == apb_chk_pkg::PH_ACCESS);
  // Selected and the last sample did not complete the transfer
  assign mid_transfer = psel && prev_psel && !prev_pready;

  always_comb
  begin
    // A setup cycle overrides whatever the register predicted
    cur_phase = setup_cycle ? apb_chk_pkg::PH_SETUP : state_q;
    case (cur_phase)
      apb_chk_pkg::PH_SETUP:
        state_d = apb_chk_pkg::PH_ACCESS;
      // Stay while the slave stalls
      // A back-to-back transfer reappears as a setup cycle next sample
      apb_chk_pkg::PH_ACCESS:
        state_d = (psel && !pready) ? apb_chk_pkg::PH_ACCESS : apb_chk_pkg::PH_IDLE;
      default:
        state_d = apb_chk_pkg::PH_IDLE;
    endcase
  end

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      state_q <= apb_chk_pkg::PH_IDLE;
    else
      state_q <= state_d;
  end

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  // Any unselected sample or completed access restarts the count
  assign wd_reload = !psel || (penable && pready);
  // Fires once on the step to zero, then the counter parks
  assign wd_expire = !wd_reload && (wd_cnt == WD_W'(1));

  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
      wd_cnt <= WD_LOAD;
    else if (wd_reload)
      wd_cnt <= WD_LOAD;
    else if (wd_cnt != '0)
      wd_cnt <= wd_cnt - 1'b1;
  end

  //////////////////////////////////////////////////
  // Rule evaluation
  //////////////////////////////////////////////////

  always_comb
  begin
    rules_d = '0;
    // Deselect before PREADY closed the access
    rules_d[apb_chk_pkg::RULE_PSEL_DROP]       = !psel && prev_psel && !prev_pready;
    rules_d[apb_chk_pkg::RULE_PENABLE_SETUP]   = setup_cycle && penable;
    rules_d[apb_chk_pkg::RULE_PENABLE_ACCESS]  = access_cycle && !penable;
    // Address and control held until the slave answers
    rules_d[apb_chk_pkg::RULE_PADDR_UNSTABLE]  = mid_transfer && (paddr != prev_paddr);
    rules_d[apb_chk_pkg::RULE_PWRITE_UNSTABLE] = mid_transfer && (pwrite != prev_pwrite);
    rules_d[apb_chk_pkg::RULE_PWDATA_UNSTABLE] = mid_transfer && (pwdata != prev_pwdata);
    rules_d[apb_chk_pkg::RULE_PADDR_ALIGN]     = psel && (|paddr[ALIGN_W-1:0]);
    rules_d[apb_chk_pkg::RULE_WATCHDOG]        = wd_expire;
  end

  //////////////////////////////////////////////////
  // Sample history and record output
  //////////////////////////////////////////////////

  // PREADY resets high so the first select counts as a setup
  always_ff @(posedge PCLK or negedge PRESETn)
  begin
    if (!PRESETn)
    begin
      prev_psel    <= 1'b0;
      prev_penable <= 1'b0;
      prev_pready  <= 1'b1;
      rec_push     <= 1'b0;
    end
    else
    begin
      prev_psel    <= psel;
      prev_penable <= penable;
      prev_pready  <= pready;
      rec_push     <= |rules_d;
    end
  end

  // Bus payload and record contents
  always_ff @(posedge PCLK)
  begin
    prev_paddr  <= paddr;
    prev_pwrite <= pwrite;
    prev_pwdata <= pwdata;
    rec.rules   <= rules_d;
  end

  // Access phase only follows a selected sample
  a_access_after_psel : assert property (@(posedge PCLK) disable iff (!PRESETn)
    state_q == apb_chk_pkg::PH_ACCESS |-> $past(psel));

  // Never push an empty record into the log
  a_push_nonzero : assert property (@(posedge PCLK) disable iff (!PRESETn)
    rec_push |-> (rec.rules != '0));

endmodule

// File: src/apb_chk_pkg.sv
// Shared checker types; widths follow the macros header, so it must be on the include path
`include "apb_chk_macros.svh"

package apb_chk_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // One APB address
  typedef logic [`APB_CHK_ADDR_W-1:0] paddr_t;

  // One APB write data word
  typedef logic [`APB_CHK_DATA_W-1:0] pdata_t;

  // One bit per rule, indexed by rule_idx_e
  typedef logic [7:0] rule_vec_t;

  // Saturating violation count
  typedef logic [`APB_CHK_COUNT_W-1:0] err_count_t;

  //////////////////////////////////////////////////
  // Enums
  //////////////////////////////////////////////////

  // Rule bit positions inside rule_vec_t
  typedef enum logic [2:0] {
    RULE_PSEL_DROP,
    RULE_PENABLE_SETUP,
    RULE_PENABLE_ACCESS,
    RULE_PADDR_UNSTABLE,
    RULE_PWRITE_UNSTABLE,
    RULE_PWDATA_UNSTABLE,
    RULE_PADDR_ALIGN,
    RULE_WATCHDOG
  } rule_idx_e;

  // Monitor view of the bus phase
  typedef enum logic [1:0] {
    PH_IDLE,
    PH_SETUP,
    PH_ACCESS
  } bus_phase_e;

  // One log entry per offending bus sample
  typedef struct packed {
    rule_vec_t rules;
  } viol_rec_t;

endpackage

// File: src/apb_chk_macros.svh
// Build-time sizes for the APB3 checker; DATA_W must be 16 or more and LOG_DEPTH at least 2
`ifndef APB_CHK_MACROS_SVH
`define APB_CHK_MACROS_SVH

//////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////

// PADDR width in bits
`define APB_CHK_ADDR_W 32

// PWDATA width in bits
// Its byte count sets how many low PADDR bits must be zero
`define APB_CHK_DATA_W 32

//////////////////////////////////////////////////
// Checker sizing
//////////////////////////////////////////////////

// Violation records held by the log before overflow
`define APB_CHK_LOG_DEPTH 8

// Selected samples a transfer may run without completing
`define APB_CHK_WATCHDOG_CYCLES 16

// Width of the saturating error count
`define APB_CHK_COUNT_W 16

`endif
